/* hdl/exc_settings.svh */
`ifndef EXC_SETTINGS_SVH
`define EXC_SETTINGS_SVH

// vector bases and offsets for exception entry.
`define EXC_BEV_BASE     32'hBFC0_0200
`define EXC_OFF_GENERAL  32'h0000_0180
`define EXC_OFF_INT      32'h0000_0200

// reset values.
`define EBASE_RESET      32'h8000_0000
`define STATUS_RESET     32'h0040_0004 // BEV and ERL set.

// register numbers on the mtc0/mfc0 port.
`define CP0_SEL_BADVADDR 5'd8
`define CP0_SEL_STATUS   5'd12
`define CP0_SEL_CAUSE    5'd13
`define CP0_SEL_EPC      5'd14
`define CP0_SEL_EBASE    5'd15

`endif

/* hdl/exc_pkg.sv */
package exc_pkg;

    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        CPU  = 5'd11,
        OV   = 5'd12,
        TR   = 5'd13
    } exc_code_e;

    // which instruction check the decoder asked for.
    typedef enum logic [2:0] {
        NONE     = 3'd0,
        SYSCALL  = 3'd1,
        BREAK    = 3'd2,
        TRAP     = 3'd3,
        OVERFLOW = 3'd4,
        RESERVED = 3'd5
    } exc_chk_e;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic [8:0] rsvd_31_23;
        logic       bev;        // bit 22.
        logic [5:0] rsvd_21_16;
        logic [7:0] im;         // bits 15:8.
        logic [2:0] rsvd_7_5;
        logic       um;         // bit 4.
        logic       rsvd_3;
        logic       erl;
        logic       exl;
        logic       ie;
    } status_fields_t;

    typedef union packed {
        logic [31:0]    raw;
        status_fields_t fields;
    } status_u;

    typedef struct packed {
        logic       bd;         // bit 31.
        logic       rsvd_30;
        logic [1:0] ce;         // bits 29:28.
        logic [3:0] rsvd_27_24;
        logic       iv;         // bit 23.
        logic [6:0] rsvd_22_16;
        logic [7:0] ip;         // bits 15:8.
        logic       rsvd_7;
        exc_code_e  exc_code;   // bits 6:2.
        logic [1:0] rsvd_1_0;
    } cause_fields_t;

    typedef union packed {
        logic [31:0]   raw;
        cause_fields_t fields;
    } cause_u;

    // everything cop0_regs needs to commit one exception.
    typedef struct packed {
        logic        taken;
        exc_code_e   code;
        logic [31:0] epc;
        logic        in_bd;
        logic        load_badvaddr;
        logic [31:0] badvaddr;
        logic [1:0]  ce;
        logic [5:0]  ip_hw;
    } exc_data_t;

endpackage

/* hdl/stage_if.sv */
`timescale 1ns/1ps

interface stage_if;
    logic                valid;
    logic [31:0]         pc;
    logic [31:0]         instruction;
    logic [31:0]         mem_addr;
    exc_pkg::exc_chk_e   exc_chk;
    logic                mem_read;
    logic                mem_write;
    exc_pkg::mem_size_e  mem_size;
    logic                overflow;
    logic                trap_taken;
    logic                prev_branch; // this instruction sits in a delay slot.

    modport source (output valid, pc, instruction, mem_addr, exc_chk, mem_read,
                    mem_write, mem_size, overflow, trap_taken, prev_branch);
    modport sink (input valid, pc, instruction, mem_addr, exc_chk, mem_read,
                  mem_write, mem_size, overflow, trap_taken, prev_branch);
endinterface

interface cop0_state_if;
    exc_pkg::status_u status;
    exc_pkg::cause_u  cause;
    logic [31:0]      ebase;
    logic [5:0]       int_sync;

    modport owner (output status, cause, ebase, int_sync);
    modport reader (input status, cause, ebase, int_sync);
endinterface

/* hdl/address_error_checker.sv */
`timescale 1ns/1ps

module address_error_checker (
    input  logic               [31:0] pc,
    input  logic               [31:0] mem_addr,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  exc_pkg::mem_size_e        mem_size,
    input  logic                      kernel_mode,
    output logic                      read_error,
    output logic                      store_error,
    output logic               [31:0] bad_addr
);
    logic fetch_error;
    logic misaligned;
    logic data_error;

    always_comb begin
        case (mem_size)
            exc_pkg::HALF: misaligned = mem_addr[0];
            exc_pkg::WORD: misaligned = |mem_addr[1:0];
            default:       misaligned = 1'b0; // a byte access is always aligned.
        endcase
    end

    assign fetch_error = |pc[1:0];

    // user code may not touch kseg0 and above.
    assign data_error = misaligned | (mem_addr[31] & ~kernel_mode);

    // a bad fetch is reported as a load error.
    assign read_error  = fetch_error | (mem_read & data_error);
    assign store_error = ~fetch_error & mem_write & data_error;

    assign bad_addr = fetch_error ? pc : mem_addr;

endmodule

/* hdl/exception_controller.sv */
`timescale 1ns/1ps
`include "exc_settings.svh"

module exception_controller (
    stage_if.sink                   ex,
    cop0_state_if.reader            cp0,
    output exc_pkg::exc_data_t      exc,
    output logic             [31:0] exc_addr,
    output logic                    any_interrupt
);
    localparam logic [5:0] OPCODE_COP0 = 6'h10;

    logic        kernel_mode;
    logic        int_enable;
    logic [7:0]  int_masked;
    logic        read_error;
    logic        store_error;
    logic [31:0] bad_addr;
    logic        is_cop0;
    logic        int_vectored;
    logic [31:0] vec_base;
    logic [31:0] vec_offset;

    assign kernel_mode = cp0.status.fields.erl | cp0.status.fields.exl
                       | ~cp0.status.fields.um;

    // interrupts are blocked inside a handler or on the error level.
    assign int_enable = cp0.status.fields.ie & ~cp0.status.fields.exl
                      & ~cp0.status.fields.erl;

    assign int_masked = {cp0.int_sync, cp0.cause.fields.ip[1:0]}
                      & cp0.status.fields.im & {8{int_enable}};
    assign any_interrupt = |int_masked;

    assign is_cop0 = (ex.instruction[31:26] == OPCODE_COP0);

    address_error_checker u_address_error_checker (
        .pc          (ex.pc),
        .mem_addr    (ex.mem_addr),
        .mem_read    (ex.mem_read),
        .mem_write   (ex.mem_write),
        .mem_size    (ex.mem_size),
        .kernel_mode (kernel_mode),
        .read_error  (read_error),
        .store_error (store_error),
        .bad_addr    (bad_addr)
    );

    always_comb begin
        exc = '0;
        exc.ip_hw = int_masked[7:2];

        if (any_interrupt) begin
            // a pending interrupt is taken even in a bubble.
            exc.taken = 1'b1;
            exc.code  = exc_pkg::INT;
        end else if (ex.valid) begin
            if (read_error || store_error) begin
                exc.taken         = 1'b1;
                exc.load_badvaddr = 1'b1;
                exc.badvaddr      = bad_addr;
                exc.code          = read_error ? exc_pkg::ADEL : exc_pkg::ADES;
            end else begin
                case (ex.exc_chk)
                    exc_pkg::SYSCALL: begin
                        exc.taken = 1'b1;
                        exc.code  = exc_pkg::SYS;
                    end
                    exc_pkg::BREAK: begin
                        exc.taken = 1'b1;
                        exc.code  = exc_pkg::BP;
                    end
                    exc_pkg::TRAP: begin
                        exc.taken = ex.trap_taken; // only a met trap condition.
                        exc.code  = exc_pkg::TR;
                    end
                    exc_pkg::OVERFLOW: begin
                        exc.taken = ex.overflow;
                        exc.code  = exc_pkg::OV;
                    end
                    exc_pkg::RESERVED: begin
                        exc.taken = 1'b1;
                        exc.code  = exc_pkg::RI;
                    end
                    default: begin
                        exc.taken = 1'b0;
                    end
                endcase
            end

            // cp0 access from user mode beats every other synchronous cause.
            if (!kernel_mode && is_cop0) begin
                exc.taken         = 1'b1;
                exc.code          = exc_pkg::CPU;
                exc.ce            = 2'd0;
                exc.load_badvaddr = 1'b0;
            end
        end

        if (ex.prev_branch) begin
            exc.epc   = ex.pc - 32'd4; // restart at the branch.
            exc.in_bd = 1'b1;
        end else begin
            exc.epc   = ex.pc;
            exc.in_bd = 1'b0;
        end
    end

    assign int_vectored = exc.taken && (exc.code == exc_pkg::INT) && cp0.cause.fields.iv;

    assign vec_offset = int_vectored ? `EXC_OFF_INT : `EXC_OFF_GENERAL;
    assign vec_base   = cp0.status.fields.bev ? `EXC_BEV_BASE : cp0.ebase;
    assign exc_addr   = vec_base + vec_offset;

endmodule

/* hdl/cop0_regs.sv */
`timescale 1ns/1ps
`include "exc_settings.svh"

module cop0_regs (
    input  logic                      clk,
    input  logic                      reset,
    input  logic               [5:0]  hardware_int,
    input  exc_pkg::exc_data_t        exc,
    input  logic                      eret,
    input  logic                      cop0_we,
    input  logic               [4:0]  cop0_wsel,
    input  logic               [31:0] cop0_wdata,
    input  logic               [4:0]  cop0_rsel,
    output logic               [31:0] cop0_rdata,
    cop0_state_if.owner               cp0
);
    exc_pkg::status_u status;
    exc_pkg::cause_u  cause;
    logic [31:0]      ebase;
    logic [31:0]      epc;
    logic [31:0]      badvaddr;
    logic [5:0]       int_meta;
    logic [5:0]       int_sync;
    exc_pkg::status_u wr_status;
    exc_pkg::cause_u  wr_cause;

    assign wr_status.raw = cop0_wdata;
    assign wr_cause.raw  = cop0_wdata;

    // two flops on each hardware line.
    always_ff @(posedge clk) begin
        if (reset) begin
            int_meta <= '0;
            int_sync <= '0;
        end else begin
            int_meta <= hardware_int;
            int_sync <= int_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            status.raw <= `STATUS_RESET;
            cause.raw  <= '0;
            ebase      <= `EBASE_RESET;
        end else if (exc.taken) begin
            status.fields.exl      <= 1'b1;
            cause.fields.exc_code  <= exc.code;
            cause.fields.ip[7:2]   <= exc.ip_hw;
            cause.fields.ce        <= exc.ce;
            if (!status.fields.exl) begin
                cause.fields.bd <= exc.in_bd; // only the outermost exception sets BD.
            end
        end else if (eret) begin
            status.fields.exl <= 1'b0;
        end else if (cop0_we) begin
            case (cop0_wsel)
                `CP0_SEL_STATUS: begin
                    status.fields.bev <= wr_status.fields.bev;
                    status.fields.im  <= wr_status.fields.im;
                    status.fields.um  <= wr_status.fields.um;
                    status.fields.erl <= wr_status.fields.erl;
                    status.fields.exl <= wr_status.fields.exl;
                    status.fields.ie  <= wr_status.fields.ie;
                end
                `CP0_SEL_CAUSE: begin
                    cause.fields.iv      <= wr_cause.fields.iv;
                    cause.fields.ip[1:0] <= wr_cause.fields.ip[1:0]; // soft requests.
                end
                `CP0_SEL_EBASE: begin
                    ebase[29:12] <= cop0_wdata[29:12];
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (exc.taken) begin
            if (!status.fields.exl) begin
                epc <= exc.epc;
            end
            if (exc.load_badvaddr) begin
                badvaddr <= exc.badvaddr;
            end
        end else if (cop0_we && cop0_wsel == `CP0_SEL_EPC) begin
            epc <= cop0_wdata;
        end
    end

    always_comb begin
        case (cop0_rsel)
            `CP0_SEL_BADVADDR: cop0_rdata = badvaddr;
            `CP0_SEL_STATUS:   cop0_rdata = status.raw;
            `CP0_SEL_CAUSE:    cop0_rdata = cause.raw;
            `CP0_SEL_EPC:      cop0_rdata = epc;
            `CP0_SEL_EBASE:    cop0_rdata = ebase;
            default:           cop0_rdata = '0;
        endcase
    end

    assign cp0.status   = status;
    assign cp0.cause    = cause;
    assign cp0.ebase    = ebase;
    assign cp0.int_sync = int_sync;

endmodule

/* hdl/exc_unit_top.sv */
`timescale 1ns/1ps

module exc_unit_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ex_valid,
    input  logic               [31:0] ex_pc,
    input  logic               [31:0] ex_instruction,
    input  logic               [31:0] ex_mem_addr,
    input  exc_pkg::exc_chk_e         ex_exc_chk,
    input  logic                      ex_mem_read,
    input  logic                      ex_mem_write,
    input  exc_pkg::mem_size_e        ex_mem_size,
    input  logic                      ex_overflow,
    input  logic                      ex_trap_taken,
    input  logic                      ex_prev_branch,
    input  logic                      eret,
    input  logic               [5:0]  hardware_int,
    input  logic                      cop0_we,
    input  logic               [4:0]  cop0_wsel,
    input  logic               [31:0] cop0_wdata,
    input  logic               [4:0]  cop0_rsel,
    output logic               [31:0] cop0_rdata,
    output logic                      exception,
    output exc_pkg::exc_code_e        exc_code,
    output logic               [31:0] exc_addr,
    output logic                      any_interrupt
);
    stage_if            ex_if ();
    cop0_state_if       cp0_if ();
    exc_pkg::exc_data_t exc;

    assign ex_if.valid       = ex_valid;
    assign ex_if.pc          = ex_pc;
    assign ex_if.instruction = ex_instruction;
    assign ex_if.mem_addr    = ex_mem_addr;
    assign ex_if.exc_chk     = ex_exc_chk;
    assign ex_if.mem_read    = ex_mem_read;
    assign ex_if.mem_write   = ex_mem_write;
    assign ex_if.mem_size    = ex_mem_size;
    assign ex_if.overflow    = ex_overflow;
    assign ex_if.trap_taken  = ex_trap_taken;
    assign ex_if.prev_branch = ex_prev_branch;

    exception_controller u_exception_controller (
        .ex            (ex_if.sink),
        .cp0           (cp0_if.reader),
        .exc           (exc),
        .exc_addr      (exc_addr),
        .any_interrupt (any_interrupt)
    );

    cop0_regs u_cop0_regs (
        .clk          (clk),
        .reset        (reset),
        .hardware_int (hardware_int),
        .exc          (exc),
        .eret         (eret),
        .cop0_we      (cop0_we),
        .cop0_wsel    (cop0_wsel),
        .cop0_wdata   (cop0_wdata),
        .cop0_rsel    (cop0_rsel),
        .cop0_rdata   (cop0_rdata),
        .cp0          (cp0_if.owner)
    );

    assign exception = exc.taken;
    assign exc_code  = exc.code;

endmodule

/* verification/exc_tb_cases.svh */
// exec_step: name, valid, pc, chk, mem {wr,rd}, size, mem_addr, cond, prev_branch, hw,
//            cop0 opcode, expected exception, expected code, expected exc_addr.
// chk 0 none 1 syscall 2 break 3 trap 4 overflow 5 reserved; size 0 byte 1 half 2 word.
function automatic void build_table();
    exec_step("syscall", 1, 'h00400000, 1, 0, 0, 0, 0, 0, 0, 0, 1, 8, 'hBFC00380);
    exec_step("break", 1, 'h00400004, 2, 0, 0, 0, 0, 0, 0, 0, 1, 9, 'hBFC00380);
    exec_step("reserved", 1, 'h00400008, 5, 0, 0, 0, 0, 0, 0, 0, 1, 10, 'hBFC00380);
    exec_step("trap taken", 1, 'h0040000C, 3, 0, 0, 0, 1, 0, 0, 0, 1, 13, 'hBFC00380);
    exec_step("trap not taken", 1, 'h00400010, 3, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    exec_step("overflow", 1, 'h00400014, 4, 0, 0, 0, 1, 0, 0, 0, 1, 12, 'hBFC00380);
    exec_step("no overflow", 1, 'h00400018, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    exec_step("lw misaligned", 1, 'h0040001C, 0, 1, 2, 'h10000002, 0, 0, 0, 0, 1, 4, 'hBFC00380);
    mfc0_step("badvaddr of lw", `CP0_SEL_BADVADDR, 'h10000002);
    exec_step("sh misaligned", 1, 'h00400020, 0, 2, 1, 'h10000005, 0, 0, 0, 0, 1, 5, 'hBFC00380);
    mfc0_step("badvaddr of sh", `CP0_SEL_BADVADDR, 'h10000005);
    mtc0_step("enter user mode", `CP0_SEL_STATUS, 'h00400010);
    mfc0_step("status user", `CP0_SEL_STATUS, 'h00400010);
    exec_step("user kseg0 load", 1, 'h00400100, 0, 1, 2, 'h80000000, 0, 0, 0, 0, 1, 4, 'hBFC00380);
    mfc0_step("badvaddr of kseg0", `CP0_SEL_BADVADDR, 'h80000000);
    mfc0_step("epc of kseg0", `CP0_SEL_EPC, 'h00400100);
    mtc0_step("clear exl", `CP0_SEL_STATUS, 'h00400000);
    exec_step("delay slot", 1, 'h00400204, 1, 0, 0, 0, 0, 1, 0, 0, 1, 8, 'hBFC00380);
    mfc0_step("epc delay slot", `CP0_SEL_EPC, 'h00400200);
    mfc0_step("cause delay slot", `CP0_SEL_CAUSE, 'h80000020);
    exec_step("nested break", 1, 'h00400300, 2, 0, 0, 0, 0, 0, 0, 0, 1, 9, 'hBFC00380);
    mfc0_step("epc kept", `CP0_SEL_EPC, 'h00400200);
    mtc0_step("clear exl again", `CP0_SEL_STATUS, 'h00400000);
    exec_step("no delay slot", 1, 'h00400400, 1, 0, 0, 0, 0, 0, 0, 0, 1, 8, 'hBFC00380);
    mfc0_step("epc no delay slot", `CP0_SEL_EPC, 'h00400400);
    mfc0_step("cause no delay slot", `CP0_SEL_CAUSE, 'h00000020);
    mtc0_step("write ebase", `CP0_SEL_EBASE, 'h00012000);
    mfc0_step("read ebase", `CP0_SEL_EBASE, 'h80012000);
    mtc0_step("soft request", `CP0_SEL_CAUSE, 'h00000100);
    mtc0_step("enable im0", `CP0_SEL_STATUS, 'h00000101);
    exec_step("soft int", 0, 'h00400500, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 'h80012180);
    mtc0_step("vectored request", `CP0_SEL_CAUSE, 'h00800100);
    eret_step("eret vectored");
    exec_step("vectored int", 0, 'h00400504, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 'h80012200);
    mtc0_step("clear request", `CP0_SEL_CAUSE, 'h00000000);
    eret_step("eret before hw");
    exec_step("hw line masked", 0, 'h00400508, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0);
    mtc0_step("enable im2", `CP0_SEL_STATUS, 'h00000403);
    eret_step("eret into hw");
    exec_step("hw int", 0, 'h0040050C, 0, 0, 0, 0, 0, 0, 1, 0, 1, 0, 'h80012180);
    mfc0_step("cause hw int", `CP0_SEL_CAUSE, 'h00000400);
    mtc0_step("user again", `CP0_SEL_STATUS, 'h00400010);
    exec_step("cop0 in user", 1, 'h00400600, 1, 0, 0, 0, 0, 0, 0, 1, 1, 11, 'hBFC00380);
    exec_step("cop0 in kernel", 1, 'h00400604, 1, 0, 0, 0, 0, 0, 0, 1, 1, 8, 'hBFC00380);
endfunction

/* verification/tb_exc_unit.sv */
`timescale 1ns/1ps
`include "exc_settings.svh"

module tb_exc_unit;
    typedef enum {WRITE, EXEC, ERET, READ} kind_e;

    typedef struct {
        string       name;
        kind_e       kind;
        logic        valid;
        logic [31:0] pc;
        logic [2:0]  chk;
        logic [1:0]  mem;       // {write, read}.
        logic [1:0]  size;
        logic [31:0] addr;      // mem_addr, or the mtc0 data.
        logic        cond;      // trap_taken and overflow.
        logic        pb;
        logic [5:0]  hw;
        logic        cop0;
        logic [4:0]  sel;
        logic        exp_exc;
        logic [4:0]  exp_code;
        logic [31:0] exp_val;   // exc_addr for EXEC, cop0_rdata for READ.
    } step_t;

    logic clk, reset, ex_valid, ex_mem_read, ex_mem_write, ex_overflow;
    logic ex_trap_taken, ex_prev_branch, eret, cop0_we, exception, any_interrupt;
    logic [31:0] ex_pc, ex_instruction, ex_mem_addr, cop0_wdata, cop0_rdata, exc_addr;
    logic [5:0] hardware_int;
    logic [4:0] cop0_wsel, cop0_rsel;
    exc_pkg::exc_chk_e ex_exc_chk;
    exc_pkg::mem_size_e ex_mem_size;
    exc_pkg::exc_code_e exc_code;
    step_t rows[$];
    int cycles = 0;

    exc_unit_top u_exc_unit_top (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic step_t make_step(kind_e kind, string name, int valid, int pc, int chk,
                                        int mem, int size, int addr, int cond, int pb, int hw,
                                        int cop0, logic [4:0] sel, int exp_exc, int code,
                                        int val);
        step_t s;
        s.name     = name;
        s.kind     = kind;
        s.valid    = valid[0];
        s.pc       = pc;
        s.chk      = chk[2:0];
        s.mem      = mem[1:0];
        s.size     = size[1:0];
        s.addr     = addr;
        s.cond     = cond[0];
        s.pb       = pb[0];
        s.hw       = hw[5:0];
        s.cop0     = cop0[0];
        s.sel      = sel;
        s.exp_exc  = exp_exc[0];
        s.exp_code = code[4:0];
        s.exp_val  = val;
        return s;
    endfunction

    function automatic void exec_step(string name, int valid, int pc, int chk, int mem, int size,
                                      int addr, int cond, int pb, int hw, int cop0,
                                      int exp_exc, int code, int val);
        rows.push_back(make_step(EXEC, name, valid, pc, chk, mem, size, addr, cond, pb, hw,
                                 cop0, 0, exp_exc, code, val));
    endfunction

    function automatic void mtc0_step(string name, logic [4:0] sel, int data);
        rows.push_back(make_step(WRITE, name, 0, 0, 0, 0, 0, data, 0, 0, 0, 0, sel, 0, 0, 0));
    endfunction

    function automatic void mfc0_step(string name, logic [4:0] sel, int val);
        rows.push_back(make_step(READ, name, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, sel, 0, 0, val));
    endfunction

    function automatic void eret_step(string name);
        rows.push_back(make_step(ERET, name, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0));
    endfunction

    `include "exc_tb_cases.svh"

    task automatic apply_step(step_t s);
        ex_valid       = s.valid;
        ex_pc          = s.pc;
        ex_instruction = s.cop0 ? 32'h4080_6000 : 32'h0000_000C; // mtc0 or syscall word.
        ex_mem_addr    = (s.kind == EXEC) ? s.addr : 32'h0;
        ex_exc_chk     = exc_pkg::exc_chk_e'(s.chk);
        ex_mem_read    = s.mem[0];
        ex_mem_write   = s.mem[1];
        ex_mem_size    = exc_pkg::mem_size_e'(s.size);
        ex_overflow    = s.cond;
        ex_trap_taken  = s.cond;
        ex_prev_branch = s.pb;
        eret           = (s.kind == ERET);
        hardware_int   = s.hw;
        cop0_we        = (s.kind == WRITE);
        cop0_wsel      = s.sel;
        cop0_wdata     = s.addr;
        cop0_rsel      = s.sel;
    endtask

    task automatic report_failure(string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp)
            report_failure($sformatf("** Error %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_word(string name, logic [31:0] exp, logic [31:0] act);
        if (act !== exp)
            report_failure($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_code(string name, exc_pkg::exc_code_e exp, exc_pkg::exc_code_e act);
        if (act !== exp)
            report_failure($sformatf("** Error %s: expected %s, actual %s",
                                     name, exp.name(), act.name()));
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > 8 * rows.size() + 50)
            report_failure("timeout: the table did not finish within the cycle limit");
    end

    initial begin
        apply_step(make_step(READ, "idle", 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0));
        reset = 1'b1;
        build_table();
        repeat (10) @(posedge clk);
        #5 reset = 1'b0;
        foreach (rows[i]) begin
            apply_step(rows[i]);
            if (rows[i].hw != 0)
                repeat (2) @(posedge clk); // two synchronizer stages.
            @(negedge clk);
            #40;
            if (rows[i].kind == READ) begin
                check_word(rows[i].name, rows[i].exp_val, cop0_rdata);
            end else begin
                check_bit(rows[i].name, rows[i].exp_exc, exception);
                // only a pending interrupt may raise the interrupt flag.
                check_bit({rows[i].name, " any_interrupt"},
                          rows[i].exp_exc && (rows[i].exp_code == exc_pkg::INT), any_interrupt);
                if (rows[i].exp_exc) begin
                    check_code(rows[i].name, exc_pkg::exc_code_e'(rows[i].exp_code), exc_code);
                    check_word(rows[i].name, rows[i].exp_val, exc_addr);
                end
            end
            @(posedge clk);
            #5;
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

/* exc_unit.f */
+incdir+hdl
+incdir+verification
hdl/exc_pkg.sv
hdl/stage_if.sv
hdl/address_error_checker.sv
hdl/exception_controller.sv
hdl/cop0_regs.sv
hdl/exc_unit_top.sv
verification/tb_exc_unit.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the exc_unit testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing -f exc_unit.f --top-module tb_exc_unit -o sim_exc_unit
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/sim_exc_unit
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
